/* run_sim.sh */
#!/usr/bin/env bash
# build the sprite display testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sprite_display -f sprite_display.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi
echo "simulation passed"

/* sprite_display.f */
src/sprite_pkg.sv
src/display_timing.sv
src/sprite_regs.sv
src/sprite_engine.sv
src/sprite_mixer.sv
src/sprite_display.sv
tests/tb_sprite_display.sv

/* src/display_timing.sv */
// display timing
// raster counters with active low syncs, data enable and line start
`timescale 1ns/1ps

module display_timing import sprite_pkg::*; #(
    parameter int H_RES  = 640,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_RES  = 480,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    output disp_pos_t pos
);

    localparam int H_TOT = H_RES + H_FP + H_SYNC + H_BP;  // full line
    localparam int V_TOT = V_RES + V_FP + V_SYNC + V_BP;  // full frame
    localparam int HS_STA = H_RES + H_FP;
    localparam int VS_STA = V_RES + V_FP;

    coord_t hcnt;
    coord_t vcnt;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == coord_t'(H_TOT-1)) begin
            hcnt <= '0;  // line wrap
            if (vcnt == coord_t'(V_TOT-1)) vcnt <= '0;  // frame wrap
            else vcnt <= vcnt + coord_t'(1);
        end else begin
            hcnt <= hcnt + coord_t'(1);
        end
    end

    always_comb begin
        pos.sx    = hcnt;
        pos.sy    = vcnt;
        pos.de    = (hcnt < coord_t'(H_RES)) && (vcnt < coord_t'(V_RES));
        // syncs low inside their own window only
        pos.hsync = !((hcnt >= coord_t'(HS_STA)) && (hcnt < coord_t'(HS_STA + H_SYNC)));
        pos.vsync = !((vcnt >= coord_t'(VS_STA)) && (vcnt < coord_t'(VS_STA + V_SYNC)));
        pos.line  = (hcnt == '0);
    end

    // counter never runs past the line total
    a_sx_range: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (pos.sx >= 0) && (pos.sx < coord_t'(H_TOT)));

endmodule

/* src/sprite_display.sv */
// sprite display top level
// timing, APB registers, a row of sprite engines and the mixer
`timescale 1ns/1ps

module sprite_display import sprite_pkg::*; #(
    parameter int    NUM_SPR   = 4,
    parameter int    SPR_SCALE = 1,
    parameter int    H_RES     = 640,
    parameter int    H_FP      = 16,
    parameter int    H_SYNC    = 96,
    parameter int    H_BP      = 48,
    parameter int    V_RES     = 480,
    parameter int    V_FP      = 10,
    parameter int    V_SYNC    = 2,
    parameter int    V_BP      = 33,
    parameter colr_t BG_COLR   = 12'h137
) (
    input  wire logic             clk_pix,
    input  wire logic             arst_n,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire logic [ADDRW-1:0] paddr,
    input  wire logic [31:0]      pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic [CHANW-1:0]      vga_r,
    output logic [CHANW-1:0]      vga_g,
    output logic [CHANW-1:0]      vga_b
);

    disp_pos_t          pos;
    spr_ctrl_t          spr_ctrl [NUM_SPR];
    spr_hit_t           hits [NUM_SPR];  // engine results, t+1
    logic               bmp_wr_en;
    logic [SPR_IDW-1:0] bmp_wr_spr;
    logic [2:0]         bmp_wr_row;
    bmp_row_t           bmp_wr_data;
    logic               pal_wr_en;
    logic [CIDXW-1:0]   pal_wr_idx;
    colr_t              pal_wr_colr;

    display_timing #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_timing (
        .clk_pix,
        .arst_n,
        .pos
    );

    sprite_regs #(.NUM_SPR(NUM_SPR)) u_regs (
        .clk_pix, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .spr_ctrl,
        .bmp_wr_en, .bmp_wr_spr, .bmp_wr_row, .bmp_wr_data,
        .pal_wr_en, .pal_wr_idx, .pal_wr_colr
    );

    // one engine per sprite, each picks its own bitmap writes
    for (genvar i = 0; i < NUM_SPR; i++) begin : gen_spr
        sprite_engine #(.SPR_ID(i), .SPR_SCALE(SPR_SCALE)) u_engine (
            .clk_pix, .arst_n, .pos,
            .ctrl(spr_ctrl[i]),
            .bmp_wr_en, .bmp_wr_spr, .bmp_wr_row, .bmp_wr_data,
            .hit(hits[i])
        );
    end

    sprite_mixer #(.NUM_SPR(NUM_SPR), .BG_COLR(BG_COLR)) u_mixer (
        .clk_pix, .arst_n, .pos, .hits,
        .pal_wr_en, .pal_wr_idx, .pal_wr_colr,
        .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b  // position t out at t+3
    );

endmodule

/* src/sprite_engine.sv */
// sprite engine
// scaled hit test of one 8x8 sprite and its bitmap pixel lookup
`timescale 1ns/1ps

module sprite_engine import sprite_pkg::*; #(
    parameter int SPR_ID    = 0,
    parameter int SPR_SCALE = 1   // on screen size 8 << SPR_SCALE
) (
    input  wire logic               clk_pix,
    input  wire logic               arst_n,
    input  wire disp_pos_t          pos,
    input  wire spr_ctrl_t          ctrl,
    input  wire logic               bmp_wr_en,
    input  wire logic [SPR_IDW-1:0] bmp_wr_spr,
    input  wire logic [2:0]         bmp_wr_row,
    input  wire bmp_row_t           bmp_wr_data,
    output spr_hit_t                hit
);

    localparam int SPR_W = SPR_SIZE << SPR_SCALE;  // on screen side

    bmp_row_t bmp_mem [SPR_SIZE];  // one word per bitmap row

    logic signed [CORDW:0] dx;  // one extra bit, sprite may be off screen
    logic signed [CORDW:0] dy;
    logic                  in_x;
    logic                  in_y;
    logic [2:0]            row;
    logic [2:0]            col;
    logic [CIDXW-1:0]      pix;

    // bitmap writes, only this sprite's rows
    always_ff @(posedge clk_pix) begin
        if (bmp_wr_en && (int'(bmp_wr_spr) == SPR_ID)) begin
            bmp_mem[bmp_wr_row] <= bmp_wr_data;
        end
    end

    // offset from sprite origin, sign extended
    assign dx = {pos.sx[CORDW-1], pos.sx} - {ctrl.x[CORDW-1], ctrl.x};
    assign dy = {pos.sy[CORDW-1], pos.sy} - {ctrl.y[CORDW-1], ctrl.y};

    assign in_x = (dx >= 0) && (dx < SPR_W);
    assign in_y = (dy >= 0) && (dy < SPR_W);

    // scale down the offset to a bitmap cell
    assign col = dx[SPR_SCALE +: 3];
    assign row = dy[SPR_SCALE +: 3];
    assign pix = bmp_mem[row].pix[col];

    // result for position t valid at t+1
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hit <= '0;
        end else begin
            hit.hit <= ctrl.en && pos.de && in_x && in_y;  // off when disabled or blanking
            hit.idx <= pix;
        end
    end

endmodule

/* src/sprite_mixer.sv */
// sprite mixer
// priority and transparency select, palette lookup and VGA output register
`timescale 1ns/1ps

module sprite_mixer import sprite_pkg::*; #(
    parameter int    NUM_SPR = 4,
    parameter colr_t BG_COLR = 12'h137
) (
    input  wire logic             clk_pix,
    input  wire logic             arst_n,
    input  wire disp_pos_t        pos,
    input  wire spr_hit_t         hits [NUM_SPR],
    input  wire logic             pal_wr_en,
    input  wire logic [CIDXW-1:0] pal_wr_idx,
    input  wire colr_t            pal_wr_colr,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic [CHANW-1:0]      vga_r,
    output logic [CHANW-1:0]      vga_g,
    output logic [CHANW-1:0]      vga_b
);

    colr_t pal_mem [2**CIDXW];  // 16 entry palette

    logic             win;      // some opaque sprite at t+1
    logic [CIDXW-1:0] win_idx;
    colr_t            pal_colr; // palette out, t+2
    colr_t            paint;
    logic             win_d2;
    logic             de_d1, de_d2;
    logic             hs_d1, hs_d2;
    logic             vs_d1, vs_d2;

    always_ff @(posedge clk_pix) begin
        if (pal_wr_en) pal_mem[pal_wr_idx] <= pal_wr_colr;
    end

    // lowest sprite number wins, walk down so it is assigned last
    always_comb begin
        win     = 1'b0;
        win_idx = '0;
        for (int i = NUM_SPR-1; i >= 0; i--) begin
            if (hits[i].hit && (hits[i].idx != TRANS_INDX)) begin
                win     = 1'b1;
                win_idx = hits[i].idx;
            end
        end
    end

    always_ff @(posedge clk_pix) pal_colr <= pal_mem[win_idx];  // registered read

    // sync and enable follow the pixel pipe
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            {de_d1, de_d2, win_d2} <= '0;
            {hs_d1, hs_d2, vs_d1, vs_d2} <= '1;  // syncs idle high
        end else begin
            de_d1  <= pos.de;
            hs_d1  <= pos.hsync;
            vs_d1  <= pos.vsync;
            de_d2  <= de_d1;
            hs_d2  <= hs_d1;
            vs_d2  <= vs_d1;
            win_d2 <= win;
        end
    end

    // sprite, else background, black in blanking
    assign paint = !de_d2 ? '0 : (win_d2 ? pal_colr : BG_COLR);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            vga_hsync <= hs_d2;
            vga_vsync <= vs_d2;
            {vga_r, vga_g, vga_b} <= paint;
        end
    end

    // blanked pixel leaves the output black a cycle later
    a_blank_black: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !de_d2 |=> ({vga_r, vga_g, vga_b} == '0));

endmodule

/* src/sprite_pkg.sv */
// sprite display shared types
// coordinates, colours, APB register words and the address map
package sprite_pkg;

    localparam int CORDW      = 12;  // signed coordinate width
    localparam int CIDXW      = 4;   // colour index width
    localparam int CHANW      = 4;   // colour channel width
    localparam int COLRW      = 3*CHANW;
    localparam int SPR_SIZE   = 8;   // bitmap side, pixels
    localparam int ADDRW      = 12;  // apb byte address width
    localparam int SPR_IDW    = 3;   // bitmap region holds eight sprites

    localparam logic [CIDXW-1:0] TRANS_INDX = 4'hF;

    // region bases, byte addresses
    localparam logic [ADDRW-1:0] ADDR_CTRL = 12'h000;  // + 4n
    localparam logic [ADDRW-1:0] ADDR_BMP  = 12'h100;  // + 32n + 4 row
    localparam logic [ADDRW-1:0] ADDR_PAL  = 12'h200;  // + 4 index

    typedef logic signed [CORDW-1:0] coord_t;

    typedef struct packed {
        logic [CHANW-1:0] r;
        logic [CHANW-1:0] g;
        logic [CHANW-1:0] b;
    } colr_t;

    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   de;     // active area
        logic   hsync;  // active low
        logic   vsync;  // active low
        logic   line;   // first cycle of a line
    } disp_pos_t;

    typedef struct packed {
        logic       en;
        logic [6:0] pad;
        coord_t     y;
        coord_t     x;
    } spr_ctrl_t;

    // pixel 0 sits in the low nibble
    typedef struct packed {
        logic [SPR_SIZE-1:0][CIDXW-1:0] pix;
    } bmp_row_t;

    typedef struct packed {
        logic [31-COLRW:0] pad;
        colr_t             colr;
    } pal_entry_t;

    // one apb write word, meaning picked by address region
    typedef union packed {
        spr_ctrl_t  ctrl;
        bmp_row_t   bmp;
        pal_entry_t pal;
    } apb_word_u;

    typedef struct packed {
        logic             hit;
        logic [CIDXW-1:0] idx;
    } spr_hit_t;

endpackage

/* src/sprite_regs.sv */
// sprite register block
// APB slave holding sprite control, forwarding bitmap and palette writes
`timescale 1ns/1ps

module sprite_regs import sprite_pkg::*; #(
    parameter int NUM_SPR = 4
) (
    input  wire logic             clk_pix,
    input  wire logic             arst_n,
    input  wire logic             psel,
    input  wire logic             penable,
    input  wire logic             pwrite,
    input  wire logic [ADDRW-1:0] paddr,
    input  wire logic [31:0]      pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output spr_ctrl_t             spr_ctrl [NUM_SPR],
    output logic                  bmp_wr_en,
    output logic [SPR_IDW-1:0]    bmp_wr_spr,
    output logic [2:0]            bmp_wr_row,
    output bmp_row_t              bmp_wr_data,
    output logic                  pal_wr_en,
    output logic [CIDXW-1:0]      pal_wr_idx,
    output colr_t                 pal_wr_colr
);

    apb_word_u  wword;     // write word, decoded per region
    logic [3:0] region;    // 256 byte region
    logic [5:0] ctrl_idx;  // control word number
    logic       in_ctrl;
    logic       in_bmp;
    logic       in_pal;
    logic       acc;       // access phase
    logic       wr;

    assign wword    = pwdata;
    assign region   = paddr[ADDRW-1:8];
    assign ctrl_idx = paddr[7:2];
    assign acc      = psel && penable;
    assign wr       = acc && pwrite;

    // region decode, sprites past NUM_SPR are unmapped
    assign in_ctrl = (region == ADDR_CTRL[ADDRW-1:8]) && (int'(ctrl_idx) < NUM_SPR);
    assign in_bmp  = (region == ADDR_BMP[ADDRW-1:8]) && (int'(paddr[7:5]) < NUM_SPR);
    assign in_pal  = (region == ADDR_PAL[ADDRW-1:8]) && (paddr[7:6] == 2'b00);

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = acc && (!(in_ctrl || in_bmp || in_pal) || (!pwrite && !in_ctrl));

    // control words, every sprite disabled from reset
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_SPR; i++) spr_ctrl[i] <= '0;
        end else if (wr && in_ctrl) begin
            for (int i = 0; i < NUM_SPR; i++) begin
                if (int'(ctrl_idx) == i) spr_ctrl[i] <= wword.ctrl;
            end
        end
    end

    always_comb begin
        prdata = '0;  // bitmap, palette and unmapped read as 0
        if (acc && !pwrite && in_ctrl) begin
            for (int i = 0; i < NUM_SPR; i++) begin
                if (int'(ctrl_idx) == i) prdata = spr_ctrl[i];
            end
        end
    end

    // write strobes, land on the same edge as a control write
    assign bmp_wr_en   = wr && in_bmp;
    assign bmp_wr_spr  = paddr[5 +: SPR_IDW];
    assign bmp_wr_row  = paddr[4:2];
    assign bmp_wr_data = wword.bmp;
    assign pal_wr_en   = wr && in_pal;
    assign pal_wr_idx  = paddr[5:2];
    assign pal_wr_colr = wword.pal.colr;

    // access phase is one cycle, so strobes never stretch
    a_bmp_pulse: assert property (@(posedge clk_pix) disable iff (!arst_n)
        bmp_wr_en |=> !bmp_wr_en);
    a_pal_pulse: assert property (@(posedge clk_pix) disable iff (!arst_n)
        pal_wr_en |=> !pal_wr_en);

endmodule

/* tests/tb_sprite_display.sv */
// sprite display testbench
// APB set-up, raster reference model and concurrent checks on the VGA outputs
`timescale 1ns/1ps

module tb_sprite_display;

    localparam int          H_RES     = 32;
    localparam int          H_FP      = 2;
    localparam int          H_SYNC    = 4;
    localparam int          H_BP      = 2;
    localparam int          V_RES     = 24;
    localparam int          V_FP      = 2;
    localparam int          V_SYNC    = 2;
    localparam int          V_BP      = 2;
    localparam int          NUM_SPR   = 4;
    localparam int          SPR_SCALE = 1;
    localparam int          SPR_W     = 8 << SPR_SCALE;  // on screen side
    localparam int          H_TOT     = H_RES + H_FP + H_SYNC + H_BP;
    localparam int          V_TOT     = V_RES + V_FP + V_SYNC + V_BP;
    localparam logic [11:0] BG        = 12'h137;
    localparam int          APB_TMO   = 16;
    localparam int          FRAME_TMO = 3 * H_TOT * V_TOT;

    // expected output of one position on its way down a 3 stage pipe
    typedef struct packed {
        logic        v;    // slot holds a real position
        logic        chk;  // colour checked here
        logic        de;
        logic        hs;
        logic        vs;
        logic [11:0] colr;
        logic [11:0] x;
        logic [11:0] y;
    } exp_pix_t;

    logic        clk_pix;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        vga_hsync;
    logic        vga_vsync;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    wire  [11:0] rgb = {vga_r, vga_g, vga_b};

    // reference model state
    logic [3:0]  m_bmp [NUM_SPR][8][8];
    logic [11:0] m_pal [16];
    logic        m_en [NUM_SPR];
    int          m_x [NUM_SPR];
    int          m_y [NUM_SPR];
    int          hc;
    int          vc;
    exp_pix_t    epipe [3];
    logic        chk = 1'b0;
    logic        rst_seen = 1'b0;
    int          seed = 21167;
    int          errors = 0;
    int          n_checks = 0;
    int          n_tests = 0;
    int          n_failed = 0;
    int          err_mark;
    int          chk_mark;
    string       cur_test = "none";
    wire         frame_end = (hc == H_TOT - 1) && (vc == V_TOT - 1);

    sprite_display #(
        .NUM_SPR(NUM_SPR), .SPR_SCALE(SPR_SCALE), .BG_COLR(BG),
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) dut0 (.*);

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    // hard stop if the run stalls
    initial begin
        #2_000_000;
        $display("simulation stalled, watchdog expired in test %s", cur_test);
        $display("Test FAILED");
        $finish;
    end

    // front sprite wins unless its cell is transparent
    function automatic logic [11:0] model_pixel(int x, int y);
        int         dx;
        int         dy;
        logic [3:0] idx;
        for (int s = 0; s < NUM_SPR; s++) begin
            dx = x - m_x[s];
            dy = y - m_y[s];
            if (m_en[s] && dx >= 0 && dx < SPR_W && dy >= 0 && dy < SPR_W) begin
                idx = m_bmp[s][dy / (2 ** SPR_SCALE)][dx / (2 ** SPR_SCALE)];
                if (idx != 4'hF) return m_pal[idx];
            end
        end
        return BG;
    endfunction

    function automatic exp_pix_t expect_at(int x, int y);
        exp_pix_t p;
        p.v    = 1'b1;
        p.chk  = chk;
        p.de   = (x < H_RES) && (y < V_RES);
        p.hs   = !(x >= H_RES + H_FP && x < H_RES + H_FP + H_SYNC);  // active low
        p.vs   = !(y >= V_RES + V_FP && y < V_RES + V_FP + V_SYNC);
        p.colr = p.de ? model_pixel(x, y) : 12'h000;
        p.x    = 12'(x);
        p.y    = 12'(y);
        return p;
    endfunction

    // raster counter from reset and the 3 cycle expected value pipe
    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hc    <= 0;
            vc    <= 0;
            epipe <= '{default: '0};
        end else begin
            epipe[0] <= expect_at(hc, vc);
            epipe[1] <= epipe[0];
            epipe[2] <= epipe[1];
            if (hc == H_TOT - 1) begin
                hc <= 0;
                vc <= (vc == V_TOT - 1) ? 0 : vc + 1;  // frame wrap
            end else begin
                hc <= hc + 1;
            end
        end
    end

    always @(posedge clk_pix) rst_seen <= 1'b1;  // outputs are not yet reset at the first edge

    always @(posedge clk_pix) begin
        if (!arst_n && rst_seen) n_checks++;
        else if (arst_n && epipe[2].v && epipe[2].chk) n_checks++;
    end

    a_reset_idle: assert property (@(posedge clk_pix)
        (!arst_n && rst_seen) |-> (vga_hsync && vga_vsync && rgb == 12'h000))
        else begin
            errors++;
            $display("Mismatch %s reset: expected hs 1 vs 1 rgb 000, actual hs %0b vs %0b rgb %03h",
                     cur_test, $sampled(vga_hsync), $sampled(vga_vsync), $sampled(rgb));
        end

    a_sync: assert property (@(posedge clk_pix) disable iff (!arst_n)
        epipe[2].v |-> (vga_hsync == epipe[2].hs && vga_vsync == epipe[2].vs))
        else begin
            errors++;
            $display("Mismatch %s syncs at (%0d,%0d): expected hs %0b vs %0b, actual hs %0b vs %0b",
                     cur_test, $sampled(epipe[2].x), $sampled(epipe[2].y),
                     $sampled(epipe[2].hs), $sampled(epipe[2].vs),
                     $sampled(vga_hsync), $sampled(vga_vsync));
        end

    a_blank: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (epipe[2].v && !epipe[2].de) |-> (rgb == 12'h000))
        else begin
            errors++;
            $display("Mismatch %s blanking at (%0d,%0d): expected 000, actual %03h",
                     cur_test, $sampled(epipe[2].x), $sampled(epipe[2].y), $sampled(rgb));
        end

    a_pixel: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (epipe[2].v && epipe[2].de && epipe[2].chk) |-> (rgb == epipe[2].colr))
        else begin
            errors++;
            $display("Mismatch %s pixel (%0d,%0d): expected %03h, actual %03h",
                     cur_test, $sampled(epipe[2].x), $sampled(epipe[2].y),
                     $sampled(epipe[2].colr), $sampled(rgb));
        end

    task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
        n_checks++;
        a_value: assert (act === exp)
        else begin
            errors++;
            $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
        end
    endtask

    // setup phase, access phase, then wait for pready
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk_pix);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_pix);
        penable <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk_pix);
            waited++;
        end while (!pready && waited < APB_TMO);
        if (!pready) begin
            errors++;
            $display("APB access to 0x%03h saw no pready in test %s", addr, cur_test);
        end
        rdata = prdata;  // still the access phase values
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(logic [11:0] addr, logic [31:0] data, logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_val($sformatf("pslverr write 0x%03h", addr), 32'(exp_err), 32'(err));
    endtask

    task automatic apb_read_check(logic [11:0] addr, logic [31:0] exp_data, logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check_val($sformatf("prdata 0x%03h", addr), exp_data, rd);
        check_val($sformatf("pslverr read 0x%03h", addr), 32'(exp_err), 32'(err));
    endtask

    function automatic logic [31:0] ctrl_word(int s);
        return {m_en[s], 7'b0, 12'(m_y[s]), 12'(m_x[s])};  // en, pad, y, x
    endfunction

    function automatic logic [3:0] rand_idx(bit opaque);
        logic [3:0] v;
        v = 4'($random(seed));
        if (opaque && v == 4'hF) v = 4'h0;
        return v;
    endfunction

    // random bitmap with optional diagonal stripes of transparent cells
    task automatic fill_bitmap(int s, bit opaque, int holes);
        logic [31:0] word;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                m_bmp[s][r][c] = rand_idx(opaque);
                if (holes > 0 && (r + c) % holes == 0) m_bmp[s][r][c] = 4'hF;
                word[4*c +: 4] = m_bmp[s][r][c];  // pixel 0 low nibble
            end
            apb_write(12'h100 + 12'(32 * s + 4 * r), word, 1'b0);
        end
    endtask

    task automatic place_sprite(int s, logic en, int x, int y);
        m_en[s] = en;
        m_x[s]  = x;
        m_y[s]  = y;
        apb_write(12'(4 * s), ctrl_word(s), 1'b0);
    endtask

    task automatic load_palette();
        for (int i = 0; i < 16; i++) begin
            m_pal[i] = 12'($random(seed));
            apb_write(12'h200 + 12'(4 * i), {20'h0, m_pal[i]}, 1'b0);
        end
    endtask

    task automatic wait_frame_end();
        int waited;
        waited = 0;
        do begin
            @(posedge clk_pix);
            waited++;
        end while (!frame_end && waited < FRAME_TMO);
        if (!frame_end) begin
            errors++;
            $display("no frame end within %0d cycles in test %s", FRAME_TMO, cur_test);
        end
    endtask

    // colour checks cover whole frames
    task automatic open_window();
        wait_frame_end();
        chk <= 1'b1;
    endtask

    task automatic close_window();
        wait_frame_end();
        chk <= 1'b0;
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        err_mark = errors;
        chk_mark = n_checks;
    endtask

    task automatic end_test();
        int errs;
        int chks;
        repeat (4) @(posedge clk_pix);  // drain the 3 cycle pixel pipe
        errs = errors - err_mark;
        chks = n_checks - chk_mark;
        n_tests++;
        if (chks == 0) begin
            $display("no checks were reached in test %s", cur_test);
            errors++;
            errs++;
        end
        if (errs == 0) begin
            $display("pass %s, %0d checks", cur_test, chks);
        end else begin
            n_failed++;
            $display("FAIL %s, %0d errors in %0d checks", cur_test, errs, chks);
        end
    endtask

    initial begin
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int s = 0; s < NUM_SPR; s++) begin
            m_en[s] = 1'b0;  // sprites come out of reset disabled
            m_x[s]  = 0;
            m_y[s]  = 0;
        end

        begin_test("reset");
        repeat (4) @(posedge clk_pix);
        arst_n <= 1'b1;
        end_test();

        begin_test("sync_background");
        load_palette();
        open_window();
        close_window();
        end_test();

        begin_test("scaled_sprite");
        fill_bitmap(0, 1'b1, 0);
        place_sprite(0, 1'b1, 5, 3);
        open_window();
        close_window();
        end_test();

        // sprite 1 has holes and sprite 2 sits behind it past the right edge
        begin_test("transparency");
        place_sprite(0, 1'b0, 5, 3);
        fill_bitmap(1, 1'b1, 3);
        fill_bitmap(2, 1'b0, 0);
        place_sprite(1, 1'b1, 12, 6);
        place_sprite(2, 1'b1, 18, 10);
        open_window();
        close_window();
        end_test();

        begin_test("priority_clip");
        fill_bitmap(0, 1'b1, 4);
        fill_bitmap(3, 1'b0, 0);
        place_sprite(0, 1'b1, -6, 4);  // clipped at the left edge
        place_sprite(3, 1'b1, 2, 8);
        open_window();
        close_window();
        end_test();

        begin_test("apb_regs");
        for (int s = 0; s < NUM_SPR; s++) apb_read_check(12'(4 * s), ctrl_word(s), 1'b0);
        apb_read_check(12'h100, 32'h0, 1'b1);
        apb_read_check(12'h21C, 32'h0, 1'b1);
        apb_read_check(12'h010, 32'h0, 1'b1);  // control slot past NUM_SPR
        apb_read_check(12'hF00, 32'h0, 1'b1);
        open_window();
        apb_write(12'h010, 32'h8000_0000, 1'b1);
        apb_write(12'h180, 32'h0000_0000, 1'b1);
        apb_write(12'h240, 32'h0000_0FFF, 1'b1);
        apb_write(12'h300, 32'hFFFF_FFFF, 1'b1);
        close_window();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0 && n_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
